//--- all.f
design/glitc_pkg.sv
design/glitc_bus_if.sv
design/glitcbus_decoder.sv
design/glitc_control_registers.sv
design/ritc_dac_registers.sv
design/ritc_dac_shifter.sv
design/ritc_max_finder.sv
design/glitc_top.sv
testbench/glitc_checker.sv
testbench/glitc_tb.sv

//--- design/glitc_bus_if.sv
`timescale 1ns/1ps

interface glitc_bus_if;
	import glitc_pkg::*;

	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              wr;
	logic              rd;

	// The decoder side follows the address and the read strobe.
	modport master (
		input addr,
		input rd
	);

	// Register blocks see the address, the write data and the write strobe.
	modport slave (
		input addr,
		input wdata,
		input wr
	);

endinterface

//--- design/glitc_control_registers.sv
`timescale 1ns/1ps

module glitc_control_registers #(
	parameter logic [31:0] VERSION = 32'h0
) (
	input  logic                         user_clk_i,
	input  logic                         reset_i,
	glitc_bus_if.slave                   bus,
	input  logic                         sel_i,
	output logic [glitc_pkg::DATA_W-1:0] dat_o,
	output logic [2:0]                   clock_ctrl_o,
	output logic                         soft_reset_o
);
	import glitc_pkg::*;

	logic ctrl_wr;

	assign ctrl_wr = bus.wr && sel_i && (bus.addr[3:0] == CTRL_CONTROL);

	////////////////////////////////////////
	// Control word.
	////////////////////////////////////////

	// Bit 31 of a control write fires the soft reset for one cycle.
	always_ff @(posedge user_clk_i) begin
		if (reset_i) begin
			clock_ctrl_o <= 3'b000;
			soft_reset_o <= 1'b0;
		end else begin
			soft_reset_o <= 1'b0;
			if (ctrl_wr) begin
				clock_ctrl_o <= bus.wdata[2:0];
				soft_reset_o <= bus.wdata[31];
			end
		end
	end

	////////////////////////////////////////
	// Readback.
	////////////////////////////////////////

	// Soft reset is self-clearing, so bit 31 always reads 0.
	always_comb begin
		case (bus.addr[3:0])
			CTRL_VERSION: dat_o = VERSION;
			CTRL_CONTROL: dat_o = {{(DATA_W-3){1'b0}}, clock_ctrl_o};
			default:      dat_o = '0;
		endcase
	end

endmodule

//--- design/glitc_pkg.sv
package glitc_pkg;

	// Local bus and datapath widths.
	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 32;
	localparam int POWER_W = 12;
	localparam int IDX_W   = 6;

	// Register blocks picked by address bits 7:4.
	typedef enum logic [3:0] {
		BLK_CTRL = 4'h0,
		BLK_DAC  = 4'h1,
		BLK_MAX  = 4'h2
	} blk_e;

	// Identification and control block.
	localparam logic [3:0] CTRL_VERSION = 4'h0;
	localparam logic [3:0] CTRL_CONTROL = 4'h1;

	// RITC DAC block.
	localparam logic [3:0] DAC_VALUE0 = 4'h0;
	localparam logic [3:0] DAC_VALUE1 = 4'h1;
	localparam logic [3:0] DAC_STATUS = 4'h2;

	// Max power finder block.
	localparam logic [3:0] MAX_RESULT = 4'h0;

	// Serial DAC shifter states.
	typedef enum logic [1:0] {
		DAC_IDLE,
		DAC_SHIFT,
		DAC_LATCH
	} dac_state_e;

	// Version fields.
	localparam logic [7:0] VER_MAJOR = 8'd0;
	localparam logic [7:0] VER_MINOR = 8'd4;
	localparam logic [7:0] VER_REV   = 8'd15;

endpackage

//--- design/glitc_top.sv
`timescale 1ns/1ps

module glitc_top #(
	parameter logic [31:0] VERSION  = {8'h00, glitc_pkg::VER_MAJOR,
	                                   glitc_pkg::VER_MINOR, glitc_pkg::VER_REV},
	parameter int          DAC_BITS = 12
) (
	input  logic                          user_clk_i,
	input  logic                          reset_i,

	input  logic [glitc_pkg::ADDR_W-1:0]  user_addr_i,
	input  logic [glitc_pkg::DATA_W-1:0]  user_dat_i,
	input  logic                          user_wr_i,
	input  logic                          user_rd_i,
	output logic [glitc_pkg::DATA_W-1:0]  user_dat_o,

	output logic [2:0]                    clock_ctrl_o,

	input  logic [glitc_pkg::POWER_W-1:0] power_i,
	input  logic                          power_valid_i,
	input  logic                          sync_i,
	output logic [glitc_pkg::POWER_W-1:0] max_o,
	output logic [glitc_pkg::IDX_W-1:0]   max_idx_o,
	output logic                          max_valid_o,

	output logic [1:0]                    dac_din_o,
	output logic [1:0]                    dac_clk_o,
	output logic [1:0]                    dac_latch_o
);

	logic                         sel_ctrl;
	logic                         sel_dac;
	logic                         sel_max;
	logic [glitc_pkg::DATA_W-1:0] ctrl_dat;
	logic [glitc_pkg::DATA_W-1:0] dac_dat;
	logic [glitc_pkg::DATA_W-1:0] max_dat;
	logic                         soft_reset;
	logic [1:0]                   dac_busy;
	logic [1:0]                   dac_start;
	logic [DAC_BITS-1:0]          dac_value0;
	logic [DAC_BITS-1:0]          dac_value1;

	////////////////////////////////////////
	// Local bus.
	////////////////////////////////////////

	glitc_bus_if u_bus ();

	assign u_bus.addr  = user_addr_i;
	assign u_bus.wdata = user_dat_i;
	assign u_bus.wr    = user_wr_i;
	assign u_bus.rd    = user_rd_i;

	glitcbus_decoder u_decoder (
		.user_clk_i (user_clk_i),
		.reset_i    (reset_i),
		.bus        (u_bus),
		.ctrl_dat_i (ctrl_dat),
		.dac_dat_i  (dac_dat),
		.max_dat_i  (max_dat),
		.sel_ctrl_o (sel_ctrl),
		.sel_dac_o  (sel_dac),
		.sel_max_o  (sel_max),
		.user_dat_o (user_dat_o)
	);

	// Identification, clock control and soft reset.
	glitc_control_registers #(.VERSION(VERSION)) u_control (
		.user_clk_i   (user_clk_i),
		.reset_i      (reset_i),
		.bus          (u_bus),
		.sel_i        (sel_ctrl),
		.dat_o        (ctrl_dat),
		.clock_ctrl_o (clock_ctrl_o),
		.soft_reset_o (soft_reset)
	);

	////////////////////////////////////////
	// RITC DAC interface.
	////////////////////////////////////////

	ritc_dac_registers #(.DAC_BITS(DAC_BITS)) u_dac_regs (
		.user_clk_i   (user_clk_i),
		.reset_i      (reset_i),
		.soft_reset_i (soft_reset),
		.bus          (u_bus),
		.sel_i        (sel_dac),
		.dat_o        (dac_dat),
		.busy_i       (dac_busy),
		.start_o      (dac_start),
		.value0_o     (dac_value0),
		.value1_o     (dac_value1)
	);

	ritc_dac_shifter #(.DAC_BITS(DAC_BITS)) u_dac_shift0 (
		.user_clk_i   (user_clk_i),
		.reset_i      (reset_i),
		.soft_reset_i (soft_reset),
		.start_i      (dac_start[0]),
		.value_i      (dac_value0),
		.busy_o       (dac_busy[0]),
		.dac_din_o    (dac_din_o[0]),
		.dac_clk_o    (dac_clk_o[0]),
		.dac_latch_o  (dac_latch_o[0])
	);

	ritc_dac_shifter #(.DAC_BITS(DAC_BITS)) u_dac_shift1 (
		.user_clk_i   (user_clk_i),
		.reset_i      (reset_i),
		.soft_reset_i (soft_reset),
		.start_i      (dac_start[1]),
		.value_i      (dac_value1),
		.busy_o       (dac_busy[1]),
		.dac_din_o    (dac_din_o[1]),
		.dac_clk_o    (dac_clk_o[1]),
		.dac_latch_o  (dac_latch_o[1])
	);

	// Max power finder.
	ritc_max_finder u_max_finder (
		.user_clk_i    (user_clk_i),
		.reset_i       (reset_i),
		.soft_reset_i  (soft_reset),
		.bus           (u_bus),
		.sel_i         (sel_max),
		.dat_o         (max_dat),
		.power_i       (power_i),
		.power_valid_i (power_valid_i),
		.sync_i        (sync_i),
		.max_o         (max_o),
		.max_idx_o     (max_idx_o),
		.max_valid_o   (max_valid_o)
	);

endmodule

//--- design/glitcbus_decoder.sv
`timescale 1ns/1ps

module glitcbus_decoder (
	input  logic                         user_clk_i,
	input  logic                         reset_i,
	glitc_bus_if.master                  bus,
	input  logic [glitc_pkg::DATA_W-1:0] ctrl_dat_i,
	input  logic [glitc_pkg::DATA_W-1:0] dac_dat_i,
	input  logic [glitc_pkg::DATA_W-1:0] max_dat_i,
	output logic                         sel_ctrl_o,
	output logic                         sel_dac_o,
	output logic                         sel_max_o,
	output logic [glitc_pkg::DATA_W-1:0] user_dat_o
);
	import glitc_pkg::*;

	blk_e              blk;
	logic [DATA_W-1:0] rd_mux;

	// Block number lives in address bits 7:4.
	assign blk = blk_e'(bus.addr[7:4]);

	assign sel_ctrl_o = (blk == BLK_CTRL);
	assign sel_dac_o  = (blk == BLK_DAC);
	assign sel_max_o  = (blk == BLK_MAX);

	// Read return mux.
	// Unmapped blocks return zero.
	always_comb begin
		case (blk)
			BLK_CTRL: rd_mux = ctrl_dat_i;
			BLK_DAC:  rd_mux = dac_dat_i;
			BLK_MAX:  rd_mux = max_dat_i;
			default:  rd_mux = '0;
		endcase
	end

	// Read data is captured on the strobe and held until the next read.
	always_ff @(posedge user_clk_i) begin
		if (reset_i) begin
			user_dat_o <= '0;
		end else if (bus.rd) begin
			user_dat_o <= rd_mux;
		end
	end

endmodule

//--- design/ritc_dac_registers.sv
`timescale 1ns/1ps

module ritc_dac_registers #(
	parameter int DAC_BITS = 12
) (
	input  logic                         user_clk_i,
	input  logic                         reset_i,
	input  logic                         soft_reset_i,
	glitc_bus_if.slave                   bus,
	input  logic                         sel_i,
	output logic [glitc_pkg::DATA_W-1:0] dat_o,
	input  logic [1:0]                   busy_i,
	output logic [1:0]                   start_o,
	output logic [DAC_BITS-1:0]          value0_o,
	output logic [DAC_BITS-1:0]          value1_o
);
	import glitc_pkg::*;

	logic [DAC_BITS-1:0] word_q [2];
	logic [1:0]          pending_q;
	logic [1:0]          wr_hit;
	logic [1:0]          launch;
	logic                clear;

	assign clear = reset_i || soft_reset_i;

	assign wr_hit[0] = bus.wr && sel_i && (bus.addr[3:0] == DAC_VALUE0);
	assign wr_hit[1] = bus.wr && sel_i && (bus.addr[3:0] == DAC_VALUE1);

	// Launch into an idle shifter only.
	// The start pulse itself blocks a second launch before busy rises.
	assign launch = pending_q & ~busy_i & ~start_o;

	////////////////////////////////////////
	// DAC words.
	////////////////////////////////////////

	// Host word, then the copy handed to the shifter at launch.
	always_ff @(posedge user_clk_i) begin
		for (int n = 0; n < 2; n++) begin
			if (wr_hit[n]) begin
				word_q[n] <= bus.wdata[DAC_BITS-1:0];
			end
		end
		if (launch[0]) begin
			value0_o <= word_q[0];
		end
		if (launch[1]) begin
			value1_o <= word_q[1];
		end
	end

	////////////////////////////////////////
	// Pending flags and start pulses.
	////////////////////////////////////////

	always_ff @(posedge user_clk_i) begin
		if (clear) begin
			pending_q <= 2'b00;
			start_o   <= 2'b00;
		end else begin
			start_o <= launch;
			// A write in the launch cycle re-arms the channel for the newer word.
			pending_q <= (pending_q & ~launch) | wr_hit;
		end
	end

	// Busy covers the start cycle too, so status never shows a gap.
	always_comb begin
		case (bus.addr[3:0])
			DAC_VALUE0: dat_o = DATA_W'(word_q[0]);
			DAC_VALUE1: dat_o = DATA_W'(word_q[1]);
			DAC_STATUS: dat_o = DATA_W'({pending_q, busy_i | start_o});
			default:    dat_o = '0;
		endcase
	end

endmodule

//--- design/ritc_dac_shifter.sv
`timescale 1ns/1ps

module ritc_dac_shifter #(
	parameter int DAC_BITS = 12
) (
	input  logic                user_clk_i,
	input  logic                reset_i,
	input  logic                soft_reset_i,
	input  logic                start_i,
	input  logic [DAC_BITS-1:0] value_i,
	output logic                busy_o,
	output logic                dac_din_o,
	output logic                dac_clk_o,
	output logic                dac_latch_o
);
	import glitc_pkg::*;

	localparam int CNT_W = (DAC_BITS > 1) ? $clog2(DAC_BITS) : 1;

	dac_state_e          state_q;
	logic [DAC_BITS-1:0] shift_q;
	logic [CNT_W-1:0]    bit_q;
	logic                clk_q;
	logic                clear;
	logic                last_bit;

	assign clear    = reset_i || soft_reset_i;
	assign last_bit = (bit_q == CNT_W'(DAC_BITS - 1));

	// Each bit gets one low and one high cycle of the DAC clock.
	// The word moves on as the clock falls, so data is steady while it is high.
	always_ff @(posedge user_clk_i) begin
		if (clear) begin
			state_q <= DAC_IDLE;
			shift_q <= '0;
			bit_q   <= '0;
			clk_q   <= 1'b0;
		end else begin
			case (state_q)
				DAC_IDLE: begin
					if (start_i) begin
						shift_q <= value_i;
						bit_q   <= '0;
						clk_q   <= 1'b0;
						state_q <= DAC_SHIFT;
					end
				end
				DAC_SHIFT: begin
					clk_q <= ~clk_q;
					if (clk_q) begin
						shift_q <= shift_q << 1;
						bit_q   <= bit_q + 1'b1;
						if (last_bit) begin
							state_q <= DAC_LATCH;
						end
					end
				end
				DAC_LATCH: begin
					// One cycle of latch, then back to idle.
					state_q <= DAC_IDLE;
				end
				default: begin
					state_q <= DAC_IDLE;
				end
			endcase
		end
	end

	// MSB first.
	// The register has shifted out to zero by the latch cycle.
	assign dac_din_o   = shift_q[DAC_BITS-1];
	assign dac_clk_o   = clk_q;
	assign dac_latch_o = (state_q == DAC_LATCH);
	assign busy_o      = (state_q != DAC_IDLE);

endmodule

//--- design/ritc_max_finder.sv
`timescale 1ns/1ps

module ritc_max_finder (
	input  logic                          user_clk_i,
	input  logic                          reset_i,
	input  logic                          soft_reset_i,
	glitc_bus_if.slave                    bus,
	input  logic                          sel_i,
	output logic [glitc_pkg::DATA_W-1:0]  dat_o,
	input  logic [glitc_pkg::POWER_W-1:0] power_i,
	input  logic                          power_valid_i,
	input  logic                          sync_i,
	output logic [glitc_pkg::POWER_W-1:0] max_o,
	output logic [glitc_pkg::IDX_W-1:0]   max_idx_o,
	output logic                          max_valid_o
);
	import glitc_pkg::*;

	logic [POWER_W-1:0] run_max_q;
	logic [IDX_W-1:0]   run_idx_q;
	logic [IDX_W:0]     count_q;
	logic               captured_q;
	logic               clear;
	logic               take;
	logic               bigger;

	assign clear = reset_i || soft_reset_i;

	// Count saturates at 64 and later samples in the window are dropped.
	assign take   = power_valid_i && !count_q[IDX_W];
	// Strictly greater keeps the first of equal maxima.
	assign bigger = (power_i > run_max_q);

	////////////////////////////////////////
	// Running window and result.
	////////////////////////////////////////

	always_ff @(posedge user_clk_i) begin
		if (clear) begin
			run_max_q   <= '0;
			run_idx_q   <= '0;
			count_q     <= '0;
			max_o       <= '0;
			max_idx_o   <= '0;
			max_valid_o <= 1'b0;
			captured_q  <= 1'b0;
		end else begin
			max_valid_o <= 1'b0;
			if (sync_i) begin
				max_o       <= run_max_q;
				max_idx_o   <= run_idx_q;
				max_valid_o <= 1'b1;
				captured_q  <= 1'b1;
				// A sample on the sync edge opens the next window.
				if (power_valid_i) begin
					run_max_q <= power_i;
					count_q   <= (IDX_W+1)'(1);
				end else begin
					run_max_q <= '0;
					count_q   <= '0;
				end
				run_idx_q <= '0;
			end else if (take) begin
				if (bigger) begin
					run_max_q <= power_i;
					run_idx_q <= count_q[IDX_W-1:0];
				end
				count_q <= count_q + 1'b1;
			end
		end
	end

	// MAX_RESULT holds the max in 11:0, the index in 21:16 and the captured flag in 31.
	always_comb begin
		dat_o = '0;
		if (sel_i && (bus.addr[3:0] == MAX_RESULT)) begin
			dat_o[DATA_W-1]     = captured_q;
			dat_o[16 +: IDX_W]  = max_idx_o;
			dat_o[POWER_W-1:0]  = max_o;
		end
	end

endmodule

//--- testbench/glitc_checker.sv
`timescale 1ns/1ps

module glitc_checker #(
	parameter int DAC_BITS = 12
) (
	input  logic        user_clk_i,
	input  logic        reset_i,
	input  logic [15:0] addr_i,
	input  logic [31:0] wdata_i,
	input  logic        wr_i,
	input  logic        rd_i,
	input  logic [31:0] rd_exp_i,
	input  logic        rd_model_i,
	input  logic [31:0] rdata_i,
	input  logic [2:0]  clock_ctrl_i,
	input  logic [11:0] power_i,
	input  logic        power_valid_i,
	input  logic        sync_i,
	input  logic [11:0] max_i,
	input  logic [5:0]  max_idx_i,
	input  logic        max_valid_i,
	input  logic [1:0]  dac_din_i,
	input  logic [1:0]  dac_clk_i,
	input  logic [1:0]  dac_latch_i
);

	// Max finder model of the open window and the last closed window.
	logic [11:0] run_max;
	logic [5:0]  run_idx;
	int          run_cnt;
	logic [11:0] res_max;
	logic [5:0]  res_idx;
	logic        res_cap;

	logic        sync_seen = 1'b0;
	logic        soft_pend = 1'b0;
	logic        rd_seen   = 1'b0;
	logic [31:0] rd_exp;
	logic [2:0]  clk_exp   = 3'b000;

	// Expected DAC words per channel, oldest first.
	logic [DAC_BITS-1:0] dac_q0 [$];
	logic [DAC_BITS-1:0] dac_q1 [$];
	logic [DAC_BITS-1:0] cap [2];
	int                  cap_cnt [2];
	logic [DAC_BITS-1:0] exp_word;
	logic [1:0]          clk_prev = 2'b00;

	int errors      = 0;
	int errs_before = 0;
	int tests       = 0;
	int failed      = 0;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic problem(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic clear_model();
		run_max = '0;
		run_idx = '0;
		run_cnt = 0;
		res_max = '0;
		res_idx = '0;
		res_cap = 1'b0;
		dac_q0.delete();
		dac_q1.delete();
		for (int ch = 0; ch < 2; ch++) begin
			cap[ch]     = '0;
			cap_cnt[ch] = 0;
		end
	endtask

	task automatic expect_dac(input int ch, input logic [DAC_BITS-1:0] word);
		if (ch == 0) begin
			dac_q0.push_back(word);
		end else begin
			dac_q1.push_back(word);
		end
	endtask

	function automatic int words_left(input int ch);
		return (ch == 0) ? dac_q0.size() : dac_q1.size();
	endfunction

	function automatic int dac_outstanding();
		return dac_q0.size() + dac_q1.size();
	endfunction

	function automatic int error_count();
		return errors;
	endfunction

	task automatic end_test(input int idx, input string what);
		tests++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", idx, what);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", idx, what, errors - errs_before);
		end
		errs_before = errors;
	endtask

	task automatic print_summary();
		if (dac_outstanding() != 0) begin
			problem("DAC words were written but never shifted out");
		end
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
	endtask

	////////////////////////////////////////
	// Inputs are sampled where the DUT samples them.
	////////////////////////////////////////

	always @(posedge user_clk_i) begin
		if (reset_i || soft_pend) begin
			// Soft reset lands one edge after its write.
			clear_model();
			soft_pend = 1'b0;
			if (reset_i) begin
				clk_exp = 3'b000;
			end
		end else begin
			if (wr_i && addr_i[7:4] == 4'h0 && addr_i[3:0] == 4'h1) begin
				clk_exp   = wdata_i[2:0];
				soft_pend = wdata_i[31];
			end
			if (rd_i) begin
				rd_seen = 1'b1;
				rd_exp  = rd_model_i ? {res_cap, 9'b0, res_idx, 4'b0, res_max} : rd_exp_i;
			end
			if (sync_i) begin
				sync_seen = 1'b1;
				res_max   = run_max;
				res_idx   = run_idx;
				res_cap   = 1'b1;
				run_idx   = '0;
				run_cnt   = power_valid_i ? 1 : 0;
				run_max   = power_valid_i ? power_i : 12'h000;
			end else if (power_valid_i && run_cnt < 64) begin
				// First strict maximum wins.
				if (power_i > run_max) begin
					run_max = power_i;
					run_idx = run_cnt[5:0];
				end
				run_cnt++;
			end
		end
	end

	////////////////////////////////////////
	// Outputs are compared mid cycle.
	////////////////////////////////////////

	always @(negedge user_clk_i) begin
		if (!reset_i) begin
			if (rd_seen) begin
				check("user_dat_o", rdata_i, rd_exp);
				rd_seen = 1'b0;
			end
			check("clock_ctrl_o", clock_ctrl_i, clk_exp);
			if (sync_seen) begin
				check("max_valid_o", max_valid_i, 1);
				check("max_o", max_i, res_max);
				check("max_idx_o", max_idx_i, res_idx);
				sync_seen = 1'b0;
			end else if (max_valid_i) begin
				problem("max_valid_o pulsed without a sync");
			end
			for (int ch = 0; ch < 2; ch++) begin
				if (dac_clk_i[ch] && !clk_prev[ch]) begin
					if (words_left(ch) == 0) begin
						problem($sformatf("DAC channel %0d clocked with no word written", ch));
					end
					cap[ch] = {cap[ch][DAC_BITS-2:0], dac_din_i[ch]};
					cap_cnt[ch]++;
				end
				if (dac_latch_i[ch]) begin
					if (words_left(ch) == 0) begin
						problem($sformatf("DAC channel %0d latched with no word written", ch));
					end else begin
						if (ch == 0) begin
							exp_word = dac_q0.pop_front();
						end else begin
							exp_word = dac_q1.pop_front();
						end
						check($sformatf("dac_din_o[%0d]", ch), cap[ch], exp_word);
						check($sformatf("dac_clk_o[%0d] pulses", ch), cap_cnt[ch], DAC_BITS);
					end
					cap[ch]     = '0;
					cap_cnt[ch] = 0;
				end
			end
		end
		clk_prev = dac_clk_i;
	end

endmodule

//--- testbench/glitc_tb.sv
`timescale 1ns/1ps

module glitc_tb;

	localparam logic [31:0] VERSION  = 32'h0000_040f;
	localparam int          DAC_BITS = 12;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDMAX, OP_DAC, OP_PWR, OP_DRAIN, OP_IDLE} op_e;

	// For OP_PWR the address holds the burst mode and the data the sample count.
	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
	} entry_t;

	logic        clk         = 1'b0;
	logic        reset       = 1'b1;
	logic [15:0] addr        = '0;
	logic [31:0] wdata       = '0;
	logic        wr          = 1'b0;
	logic        rd          = 1'b0;
	logic [31:0] rd_exp      = '0;
	logic        rd_model    = 1'b0;
	logic [11:0] power       = '0;
	logic        power_valid = 1'b0;
	logic        sync        = 1'b0;
	logic [31:0] rdata;
	logic [2:0]  clock_ctrl;
	logic [11:0] max;
	logic [5:0]  max_idx;
	logic        max_valid;
	logic [1:0]  dac_din;
	logic [1:0]  dac_clk;
	logic [1:0]  dac_latch;

	entry_t table_q [$];
	entry_t e;
	int     seed   = 32'hbc897047;
	int     cycles = 0;
	int     limit  = 0;

	always #4 clk = ~clk;

	glitc_top #(.VERSION(VERSION), .DAC_BITS(DAC_BITS)) u_glitc_top (
		.user_clk_i (clk), .reset_i (reset),
		.user_addr_i (addr), .user_dat_i (wdata), .user_wr_i (wr), .user_rd_i (rd),
		.user_dat_o (rdata), .clock_ctrl_o (clock_ctrl),
		.power_i (power), .power_valid_i (power_valid), .sync_i (sync),
		.max_o (max), .max_idx_o (max_idx), .max_valid_o (max_valid),
		.dac_din_o (dac_din), .dac_clk_o (dac_clk), .dac_latch_o (dac_latch)
	);

	glitc_checker #(.DAC_BITS(DAC_BITS)) u_checker (
		.user_clk_i (clk), .reset_i (reset),
		.addr_i (addr), .wdata_i (wdata), .wr_i (wr), .rd_i (rd),
		.rd_exp_i (rd_exp), .rd_model_i (rd_model), .rdata_i (rdata),
		.clock_ctrl_i (clock_ctrl),
		.power_i (power), .power_valid_i (power_valid), .sync_i (sync),
		.max_i (max), .max_idx_i (max_idx), .max_valid_i (max_valid),
		.dac_din_i (dac_din), .dac_clk_i (dac_clk), .dac_latch_i (dac_latch)
	);

	task automatic add(input op_e op, input logic [15:0] a, input logic [31:0] d,
			input logic [31:0] x);
		entry_t n;
		n.op   = op;
		n.addr = a;
		n.data = d;
		n.exp  = x;
		table_q.push_back(n);
	endtask

	function automatic string op_name(input logic [2:0] op);
		case (op)
			OP_WR:    return "write";
			OP_RD:    return "read";
			OP_RDMAX: return "max readback";
			OP_DAC:   return "dac word";
			OP_PWR:   return "power burst";
			OP_DRAIN: return "dac drain";
			default:  return "idle";
		endcase
	endfunction

	task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
		@(negedge clk);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, input logic [31:0] x, input logic model);
		@(negedge clk);
		addr     = a;
		rd       = 1'b1;
		rd_exp   = x;
		rd_model = model;
		@(negedge clk);
		rd = 1'b0;
	endtask

	// Mode 0 random then sync, 1 repeated equal maxima, 2 no sync, 3 sample on the sync edge.
	task automatic power_burst(input int count, input int mode);
		logic [11:0] sample;
		for (int k = 0; k < count; k++) begin
			@(negedge clk);
			sample = $random(seed);
			if (mode == 1) begin
				sample = (k % 3 == 2) ? 12'hfff : (sample & 12'h7ff);
			end
			power       = sample;
			power_valid = (mode == 1) ? 1'b1 : (($random(seed) & 3) != 0);
		end
		@(negedge clk);
		power       = $random(seed);
		power_valid = (mode == 3);
		sync        = (mode != 2);
		@(negedge clk);
		power_valid = 1'b0;
		sync        = 1'b0;
	endtask

	////////////////////////////////////////
	// Stimulus table.
	////////////////////////////////////////

	task automatic build_table();
		// Identification and control.
		add(OP_RD, 16'h0000, 0, VERSION);
		add(OP_WR, 16'h0001, 32'h0000_0005, 0);
		add(OP_RD, 16'h0001, 0, 32'h0000_0005);
		add(OP_WR, 16'h0001, 32'h8000_0003, 0);
		add(OP_RD, 16'h0001, 0, 32'h0000_0003);
		add(OP_RD, 16'h0030, 0, 0);
		add(OP_RD, 16'h00f1, 0, 0);
		// One word per channel.
		add(OP_DAC, 16'h0010, 32'h0000_0a5c, 0);
		add(OP_DRAIN, 0, 0, 0);
		add(OP_DAC, 16'h0011, 32'h0000_03f1, 0);
		add(OP_DRAIN, 0, 0, 0);
		add(OP_RD, 16'h0012, 0, 0);
		// Under back-pressure 0x456 is overwritten before channel 0 frees up.
		add(OP_DAC, 16'h0010, 32'h0000_0123, 0);
		add(OP_WR, 16'h0010, 32'h0000_0456, 0);
		add(OP_DAC, 16'h0010, 32'h0000_0789, 0);
		add(OP_DAC, 16'h0011, 32'h0000_00f0, 0);
		add(OP_RD, 16'h0012, 0, 32'h0000_0007);
		add(OP_DRAIN, 0, 0, 0);
		add(OP_RD, 16'h0012, 0, 0);
		// Power windows.
		add(OP_PWR, 0, 20, 0);
		add(OP_RDMAX, 16'h0020, 0, 0);
		add(OP_PWR, 3, 12, 0);
		add(OP_PWR, 0, 6, 0);
		add(OP_PWR, 1, 9, 0);
		add(OP_RDMAX, 16'h0020, 0, 0);
		add(OP_PWR, 0, 0, 0);
		add(OP_RDMAX, 16'h0020, 0, 0);
		add(OP_PWR, 0, 70, 0);
		// Soft reset with a shift and a window in flight.
		add(OP_DAC, 16'h0010, 32'h0000_05a5, 0);
		add(OP_PWR, 2, 8, 0);
		add(OP_WR, 16'h0001, 32'h8000_0001, 0);
		add(OP_IDLE, 0, 40, 0);
		add(OP_RD, 16'h0012, 0, 0);
		add(OP_RD, 16'h0020, 0, 0);
		add(OP_DRAIN, 0, 0, 0);
	endtask

	task automatic run_entry(input entry_t t);
		case (t.op)
			OP_WR:    bus_write(t.addr, t.data);
			OP_RD:    bus_read(t.addr, t.exp, 1'b0);
			OP_RDMAX: bus_read(t.addr, 0, 1'b1);
			OP_DAC: begin
				u_checker.expect_dac(t.addr[0], t.data[DAC_BITS-1:0]);
				bus_write(t.addr, t.data);
			end
			OP_PWR:   power_burst(t.data, t.addr);
			OP_DRAIN: begin
				while (u_checker.dac_outstanding() != 0) begin
					@(posedge clk);
				end
			end
			default:  repeat (t.data) @(posedge clk);
		endcase
	endtask

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: tests did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		build_table();
		limit = table_q.size() * 60 + 200;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < table_q.size(); i++) begin
			e = table_q[i];
			run_entry(e);
			@(posedge clk);
			u_checker.end_test(i, op_name(e.op));
		end
		u_checker.print_summary();
		if (u_checker.error_count() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
